// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbLsu
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/100ps
FILELIST  ?= tb.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(BUILD_DIR)

// ==== src/dataPort.sv ====
`timescale 1ns/100ps
`default_nettype none

module dataPort
    import memPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  rdy,

    input  logic  issue,
    input  logic  issueLoad,
    input  addrT  issueAddr,
    input  dataT  issueData,
    input  lenT   issueLen,
    input  tagT   issueTag,
    output logic  ready,

    output logic  doneValid,
    output dataT  doneData,
    output tagT   doneTag,

    memReqIf.port mem
);

    logic occupied;
    logic enPulse;
    logic donePulse;

    tagT  tag;
    logic loadReg;
    addrT addrReg;
    dataT dataReg;
    lenT  lenReg;

    assign ready = !occupied && rdy;

    // pulses stay invisible while paused
    assign mem.en    = enPulse && rdy;
    assign doneValid = donePulse && rdy;

    assign mem.load = loadReg;
    assign mem.addr = addrReg;
    assign mem.data = dataReg;
    assign mem.len  = lenReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied  <= 1'b0;
            enPulse   <= 1'b0;
            donePulse <= 1'b0;
        end else if (rdy) begin
            enPulse   <= issue;
            donePulse <= mem.done;
            if (mem.done) begin
                occupied <= 1'b0;
            end
            if (issue) begin
                occupied <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (issue) begin
                loadReg <= issueLoad;
                addrReg <= issueAddr;
                dataReg <= issueData;
                lenReg  <= issueLen;
                tag     <= issueTag;
            end
            if (mem.done) begin
                doneData <= mem.rdata;
                doneTag  <= tag;
            end
        end
    end

    // the controller only finishes the access this port started
    doneWhileOccupied: assert property (@(posedge clk) disable iff (rst)
        mem.done |-> occupied);

endmodule

`default_nettype wire

// ==== src/dataRam.sv ====
`timescale 1ns/100ps
`default_nettype none

module dataRam
    import memPkg::*;
(
    input  logic                   clk,
    input  logic                   we,
    input  logic [RamAddrBits-1:0] addr,
    input  byteT                   wdata,
    output byteT                   rdata
);

    byteT ram [2**RamAddrBits];

    // loads from bytes never written read as zero
    initial begin
        for (int i = 0; i < 2**RamAddrBits; i++) begin
            ram[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            ram[addr] <= wdata;
        end
        rdata <= ram[addr];
    end

endmodule

`default_nettype wire

// ==== src/loadStoreBuffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module loadStoreBuffer
    import memPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic rdy,

    input  logic reqValid,
    input  logic reqLoad,
    input  addrT reqAddr,
    input  dataT reqData,
    input  lenT  reqLen,
    input  tagT  reqTag,
    output logic reqReady,

    input  logic ready,
    output logic issue,
    output logic issueLoad,
    output addrT issueAddr,
    output dataT issueData,
    output lenT  issueLen,
    output tagT  issueTag
);

    logic loadQ [QueueDepth];
    addrT addrQ [QueueDepth];
    dataT dataQ [QueueDepth];
    lenT  lenQ  [QueueDepth];
    tagT  tagQ  [QueueDepth];

    logic [QueuePtrBits-1:0] head;
    logic [QueuePtrBits-1:0] tail;
    logic [QueuePtrBits:0]   count;

    logic full;
    logic enq;
    logic deq;

    assign full = count == (QueuePtrBits + 1)'(QueueDepth);

    // a paused pipeline takes nothing in
    assign reqReady = !full && rdy;
    assign enq      = reqValid && reqReady;

    // oldest entry goes out as soon as the data port is free
    assign issue = ready && (count != '0);
    assign deq   = issue;

    assign issueLoad = loadQ[head];
    assign issueAddr = addrQ[head];
    assign issueData = dataQ[head];
    assign issueLen  = lenQ[head];
    assign issueTag  = tagQ[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (enq) begin
                tail <= tail + 1'b1;
            end
            if (deq) begin
                head <= head + 1'b1;
            end
            case ({enq, deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            loadQ[tail] <= reqLoad;
            addrQ[tail] <= reqAddr;
            dataQ[tail] <= reqData;
            lenQ[tail]  <= reqLen;
            tagQ[tail]  <= reqTag;
        end
    end

    // an enqueue into a full queue would push count past the depth
    // and move tail away from head
    noEnqWhileFull: assert property (@(posedge clk) disable iff (rst)
        count <= (QueuePtrBits + 1)'(QueueDepth) && tail - head == count[QueuePtrBits-1:0]);

    // the port takes the request on this edge, so it is busy on the next one
    issueWhileReady: assert property (@(posedge clk) disable iff (rst)
        issue |-> ready ##1 !ready);

endmodule

`default_nettype wire

// ==== src/lsuTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsuTop
    import memPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic rdy,

    input  logic reqValid,
    input  logic reqLoad,
    input  addrT reqAddr,
    input  dataT reqData,
    input  lenT  reqLen,
    input  tagT  reqTag,
    output logic reqReady,

    output logic doneValid,
    output dataT doneData,
    output tagT  doneTag
);

    logic ready;
    logic issue;
    logic issueLoad;
    addrT issueAddr;
    dataT issueData;
    lenT  issueLen;
    tagT  issueTag;

    logic                   ramWe;
    logic [RamAddrBits-1:0] ramAddr;
    byteT                   ramWdata;
    byteT                   ramRdata;

    memReqIf memBus ();

    loadStoreBuffer lsb (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .reqValid  (reqValid),
        .reqLoad   (reqLoad),
        .reqAddr   (reqAddr),
        .reqData   (reqData),
        .reqLen    (reqLen),
        .reqTag    (reqTag),
        .reqReady  (reqReady),
        .ready     (ready),
        .issue     (issue),
        .issueLoad (issueLoad),
        .issueAddr (issueAddr),
        .issueData (issueData),
        .issueLen  (issueLen),
        .issueTag  (issueTag)
    );

    dataPort port (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .issue     (issue),
        .issueLoad (issueLoad),
        .issueAddr (issueAddr),
        .issueData (issueData),
        .issueLen  (issueLen),
        .issueTag  (issueTag),
        .ready     (ready),
        .doneValid (doneValid),
        .doneData  (doneData),
        .doneTag   (doneTag),
        .mem       (memBus.port)
    );

    memCtrl ctrl (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .mem      (memBus.ctrl),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    dataRam ram (
        .clk   (clk),
        .we    (ramWe),
        .addr  (ramAddr),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

endmodule

`default_nettype wire

// ==== src/memCtrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module memCtrl
    import memPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic rdy,

    memReqIf.ctrl mem,

    output logic                   ramWe,
    output logic [RamAddrBits-1:0] ramAddr,
    output byteT                   ramWdata,
    input  byteT                   ramRdata
);

    mcStateT state;

    logic [1:0] cnt;
    logic [1:0] lastLane;
    logic [1:0] rdLane;
    logic [1:0] addrLane;

    logic                   loadReg;
    logic [RamAddrBits-1:0] baseAddr;
    dataT                   wdataReg;
    lenT                    lenReg;
    dataT                   rbuf;
    dataT                   assembled;

    always_comb begin
        case (lenReg)
            LenByte: lastLane = 2'd0;
            LenHalf: lastLane = 2'd1;
            default: lastLane = 2'd3;
        endcase
    end

    // lane of the byte now on ramRdata, addressed one cycle earlier
    assign rdLane = (state == Finish) ? cnt : cnt - 2'd1;

    // while paused keep presenting the previous byte address,
    // so the RAM output still holds the pending byte on resume
    assign addrLane = rdy ? cnt : rdLane;

    assign ramAddr  = baseAddr + RamAddrBits'(addrLane);
    assign ramWe    = rdy && (state == Access) && !loadReg;
    assign ramWdata = wdataReg[{cnt, 3'b000} +: 8];

    always_comb begin
        assembled = rbuf;
        assembled[{rdLane, 3'b000} +: 8] = ramRdata;
    end

    // stores complete with zero data
    assign mem.rdata = loadReg ? assembled : '0;
    assign mem.done  = (state == Finish) && rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            cnt   <= '0;
        end else if (rdy) begin
            case (state)
                Idle: begin
                    if (mem.en) begin
                        state <= Access;
                        cnt   <= '0;
                    end
                end
                Access: begin
                    if (cnt == lastLane) begin
                        state <= Finish;
                    end else begin
                        cnt <= cnt + 2'd1;
                    end
                end
                Finish: begin
                    state <= Idle;
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (state == Idle && mem.en) begin
                loadReg  <= mem.load;
                baseAddr <= mem.addr[RamAddrBits-1:0];
                wdataReg <= mem.data;
                lenReg   <= mem.len;
                // untouched upper lanes stay zero
                rbuf     <= '0;
            end else if (state == Access && cnt != 2'd0) begin
                rbuf <= assembled;
            end
        end
    end

    // the data port must not start a second access while one is running
    enOnlyInIdle: assert property (@(posedge clk) disable iff (rst)
        mem.en |-> state == Idle);

endmodule

`default_nettype wire

// ==== src/memPkg.sv ====
`default_nettype none

package memPkg;

    typedef logic [31:0] addrT;
    typedef logic [31:0] dataT;
    typedef logic [3:0]  tagT;
    typedef logic [7:0]  byteT;

    // access length code
    typedef logic [1:0]  lenT;

    localparam lenT LenByte = 2'd0;
    localparam lenT LenHalf = 2'd1;
    localparam lenT LenWord = 2'd2;

    // RAM holds 2**RamAddrBits bytes
    localparam int RamAddrBits = 12;

    // the buffer depth is a power of two so the pointers wrap by themselves
    localparam int QueueDepth   = 8;
    localparam int QueuePtrBits = 3;

    typedef enum logic [1:0] {
        Idle,
        Access,
        Finish
    } mcStateT;

endpackage

`default_nettype wire

// ==== src/memReqIf.sv ====
`timescale 1ns/100ps
`default_nettype none

interface memReqIf
    import memPkg::*;
();

    logic en;
    logic load;
    addrT addr;
    dataT data;
    lenT  len;
    logic done;
    dataT rdata;

    // data port side
    modport port (
        output en, load, addr, data, len,
        input  done, rdata
    );

    // memory controller side
    modport ctrl (
        input  en, load, addr, data, len,
        output done, rdata
    );

endinterface

`default_nettype wire

// ==== tb.f ====
src/memPkg.sv
src/memReqIf.sv
src/loadStoreBuffer.sv
src/dataPort.sv
src/memCtrl.sv
src/dataRam.sv
src/lsuTop.sv
test/tbLsu.sv

// ==== test/tbLsu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbLsu
    import memPkg::*;
();

    localparam addrT WindowBase    = 32'h5A3C_0FF8;
    localparam int   TotalRequests = 2 + 8 + 20 + 40 + 200;
    localparam int   CycleLimit    = 8 * TotalRequests + 200;

    logic clk;
    logic rst;
    logic rdy;
    logic reqValid;
    logic reqLoad;
    addrT reqAddr;
    dataT reqData;
    lenT  reqLen;
    tagT  reqTag;
    logic reqReady;
    logic doneValid;
    dataT doneData;
    tagT  doneTag;

    byteT        shadow [2**RamAddrBits];
    dataT        expData [$];
    tagT         expTag [$];
    logic [15:0] lfsr = 16'd48;
    logic        pauseMode;
    logic        fullSeen;
    int          errCount;
    int          testStartErr;
    int          checkCount;
    int          reqCount;
    int          doneCount;

    lsuTop UUT (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .reqValid  (reqValid),
        .reqLoad   (reqLoad),
        .reqAddr   (reqAddr),
        .reqData   (reqData),
        .reqLen    (reqLen),
        .reqTag    (reqTag),
        .reqReady  (reqReady),
        .doneValid (doneValid),
        .doneData  (doneData),
        .doneTag   (doneTag)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsrBit();
        logic out;
        out = lfsr[0];
        lfsr = {1'b0, lfsr[15:1]} ^ (out ? 16'hB400 : 16'h0000);
        return out;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrBit()};
        end
        return v;
    endfunction

    function automatic int byteCount(input lenT len);
        case (len)
            LenByte: return 1;
            LenHalf: return 2;
            default: return 4;
        endcase
    endfunction

    // RAM index wraps with the RAM size
    function automatic logic [RamAddrBits-1:0] ramIndex(input addrT addr, input int offset);
        addrT a;
        a = addr + addrT'(offset);
        return a[RamAddrBits-1:0];
    endfunction

    // little-endian, zero-extended load; stores complete with zero
    function automatic dataT expectedResult(input logic load, input addrT addr, input lenT len);
        dataT v;
        v = '0;
        if (load) begin
            for (int i = 0; i < byteCount(len); i++) begin
                v[8*i +: 8] = shadow[ramIndex(addr, i)];
            end
        end
        return v;
    endfunction

    function automatic void applyStore(input addrT addr, input dataT data, input lenT len);
        for (int i = 0; i < byteCount(len); i++) begin
            shadow[ramIndex(addr, i)] = data[8*i +: 8];
        end
    endfunction

    // rdy is low about a quarter of the cycles in pause mode
    task automatic stepCycle();
        @(negedge clk);
        if (pauseMode) begin
            rdy = (randBits(2) != 32'd0);
        end else begin
            rdy = 1'b1;
        end
    endtask

    // called at a falling edge; returns at the falling edge after acceptance
    task automatic sendRequest(input logic load, input addrT addr, input dataT data,
                               input lenT len, input tagT tag);
        reqValid = 1'b1;
        reqLoad  = load;
        reqAddr  = addr;
        reqData  = data;
        reqLen   = len;
        reqTag   = tag;
        @(posedge clk);
        while (!reqReady) begin
            stepCycle();
            @(posedge clk);
        end
        stepCycle();
        reqValid = 1'b0;
    endtask

    task automatic sendRandom();
        logic load;
        addrT addr;
        dataT data;
        lenT  len;
        tagT  tag;
        load = (randBits(1) != 32'd0);
        len  = lenT'(randBits(2));
        if (len == 2'd3) begin
            len = LenWord;
        end
        addr = WindowBase + randBits(4);
        data = randBits(32);
        tag  = tagT'(randBits(4));
        sendRequest(load, addr, data, len, tag);
    endtask

    task automatic waitDrain();
        while (expData.size() != 0) begin
            stepCycle();
        end
        repeat (4) stepCycle();
    endtask

    task automatic endTest(input string name);
        $display("%s finished, %0d errors", name, errCount - testStartErr);
        testStartErr = errCount;
    endtask

    // the expected result is taken at entry since completions come back in order
    always @(posedge clk) begin : recordRequests
        if (!rst && reqValid && reqReady) begin
            expData.push_back(expectedResult(reqLoad, reqAddr, reqLen));
            expTag.push_back(reqTag);
            if (!reqLoad) begin
                applyStore(reqAddr, reqData, reqLen);
            end
            reqCount++;
        end
        if (!rst && reqValid && !reqReady && rdy) begin
            fullSeen = 1'b1;
        end
    end

    always @(posedge clk) begin : compareResults
        dataT expD;
        tagT  expT;
        if (!rst && doneValid) begin
            doneCount++;
            if (!rdy) begin
                $display("t=%0t: a completion came out while rdy was low", $time);
                errCount++;
            end
            if (expData.size() == 0) begin
                $display("t=%0t: a completion came out with no request outstanding", $time);
                errCount++;
            end else begin
                expD = expData.pop_front();
                expT = expTag.pop_front();
                checkCount++;
                if (doneData !== expD) begin
                    $display("[FAIL] t=%0t doneData got %h expected %h", $time, doneData, expD);
                    errCount++;
                end
                if (doneTag !== expT) begin
                    $display("[FAIL] t=%0t doneTag got %h expected %h", $time, doneTag, expT);
                    errCount++;
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles", cycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        rdy          = 1'b1;
        reqValid     = 1'b0;
        reqLoad      = 1'b0;
        reqAddr      = '0;
        reqData      = '0;
        reqLen       = LenByte;
        reqTag       = '0;
        pauseMode    = 1'b0;
        fullSeen     = 1'b0;
        errCount     = 0;
        testStartErr = 0;
        checkCount   = 0;
        reqCount     = 0;
        doneCount    = 0;
        for (int i = 0; i < 2**RamAddrBits; i++) begin
            shadow[i] = '0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;

        // idle after reset
        repeat (10) begin
            @(posedge clk);
            if (reqReady !== 1'b1) begin
                $display("[FAIL] t=%0t reqReady got %b expected 1", $time, reqReady);
                errCount++;
            end
            if (doneValid !== 1'b0) begin
                $display("[FAIL] t=%0t doneValid got %b expected 0", $time, doneValid);
                errCount++;
            end
        end
        @(negedge clk);
        endTest("reset state");

        sendRequest(1'b0, 32'h0000_0200, 32'hCAFE_1234, LenWord, 4'd3);
        sendRequest(1'b1, 32'h0000_0200, 32'h0000_0000, LenWord, 4'd9);
        waitDrain();
        endTest("word store then load");

        // only the low bytes of the store data may land
        sendRequest(1'b0, 32'h0000_0080, 32'hAABB_CC11, LenByte, 4'd1);
        sendRequest(1'b0, 32'h0000_0081, 32'h0000_0022, LenByte, 4'd2);
        sendRequest(1'b0, 32'h0000_0082, 32'h9F9E_4433, LenHalf, 4'd4);
        sendRequest(1'b1, 32'h0000_0080, 32'hFFFF_FFFF, LenWord, 4'd5);
        sendRequest(1'b1, 32'h0000_0080, 32'hFFFF_FFFF, LenHalf, 4'd6);
        sendRequest(1'b1, 32'h0000_0081, 32'hFFFF_FFFF, LenHalf, 4'd7);
        sendRequest(1'b1, 32'h0000_0083, 32'hFFFF_FFFF, LenByte, 4'd8);
        sendRequest(1'b1, 32'h0000_0084, 32'hFFFF_FFFF, LenByte, 4'd10);
        waitDrain();
        endTest("lengths and byte order");

        fullSeen = 1'b0;
        repeat (20) sendRandom();
        waitDrain();
        if (!fullSeen) begin
            $display("reqReady never fell during the 20-request burst");
            errCount++;
        end
        if (reqCount != doneCount) begin
            $display("%0d requests entered but %0d completed", reqCount, doneCount);
            errCount++;
        end
        endTest("ordering and full buffer");

        pauseMode = 1'b1;
        repeat (40) sendRandom();
        waitDrain();
        pauseMode = 1'b0;
        rdy = 1'b1;
        endTest("pause");

        repeat (200) begin
            if (randBits(2) == 32'd0) begin
                stepCycle();
            end
            sendRandom();
        end
        waitDrain();
        repeat (10) stepCycle();
        if (reqCount != doneCount) begin
            $display("%0d requests entered but %0d completed", reqCount, doneCount);
            errCount++;
        end
        endTest("random mix");

        $display("checks %0d, errors %0d, requests %0d, completions %0d",
                 checkCount, errCount, reqCount, doneCount);
        if (errCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
